/* vdp_regs_pkg.sv */
// VDP register map shared by the host interface, the copper and the register file.
// Addresses 0 to 31 are ordinary registers and 32 to 34 are the copper ports.
// Addresses 35 to 63 read zero and ignore writes.
`default_nettype none

package vdp_regs_pkg;

    // register word and address widths
    localparam int data_width = 16;
    localparam int address_width = 6;

    // ordinary registers sit at addresses 0 to vdp_register_count - 1
    localparam int vdp_register_count = 32;

    // sets the copper RAM write pointer
    localparam logic [address_width-1:0] cop_ram_address_reg = 6'd32;

    // stores a word at the pointer, then advances the pointer
    localparam logic [address_width-1:0] cop_ram_data_reg = 6'd33;

    // copper start / stop on write, status on read
    localparam logic [address_width-1:0] cop_control_reg = 6'd34;

    // control write: one starts from word 0, zero stops
    localparam int cop_control_start_bit = 0;

    // control read bits
    localparam int cop_status_running_bit = 0;
    localparam int cop_status_halted_bit = 1;

endpackage

`default_nettype wire

/* vdp_copper_pkg.sv */
// Copper instruction format. The opcode is always in the top two bits of a word.
// A write instruction is followed by one data word for the addressed register.
// A wait holds until the raster line is at or above the given line.
`default_nettype none

package vdp_copper_pkg;

    localparam int raster_width = 10;

    typedef enum logic [1:0] {
        op_halt  = 2'b00,
        op_write = 2'b01,
        op_wait  = 2'b10
    } cop_op_t;

    // write view: opcode, padding, target register address
    typedef struct packed {
        cop_op_t op;
        logic [vdp_regs_pkg::data_width-2-vdp_regs_pkg::address_width-1:0] unused;
        logic [vdp_regs_pkg::address_width-1:0] address;
    } cop_write_view_t;

    // wait view: opcode, padding, raster line to wait for
    typedef struct packed {
        cop_op_t op;
        logic [vdp_regs_pkg::data_width-2-raster_width-1:0] unused;
        logic [raster_width-1:0] line;
    } cop_wait_view_t;

    // one program word, decoded as either view
    typedef union packed {
        cop_write_view_t write_view;
        cop_wait_view_t wait_view;
    } copper_word_t;

endpackage

`default_nettype wire

/* vdp_host_interface.sv */
// Decodes CPU bus cycles and merges them with copper writes onto one write port.
// The CPU must hold address and data stable while its strobe is sampled high, and
// must wait for ready before it starts the next access. A CPU write always beats
// a pending copper write. The copper is also held off while a read uses the address.
`timescale 1ns/1ps
`default_nettype none

module vdp_host_interface (
    input  logic clk,
    input  logic reset,

    // CPU bus
    input  logic write_en,
    input  logic read_en,
    input  logic [vdp_regs_pkg::address_width-1:0] address,
    input  logic [vdp_regs_pkg::data_width-1:0] data_in,
    output logic ready,

    // copper write request, held until accepted
    input  logic cop_write_en,
    input  logic [vdp_regs_pkg::address_width-1:0] cop_write_address,
    input  logic [vdp_regs_pkg::data_width-1:0] cop_write_data,
    output logic cop_write_accept,

    // merged register port
    output logic reg_write_en,
    output logic [vdp_regs_pkg::address_width-1:0] reg_write_address,
    output logic [vdp_regs_pkg::data_width-1:0] reg_write_data,
    output logic read_strobe
);
    import vdp_regs_pkg::*;

    logic write_en_r;
    logic write_en_d;
    logic read_en_r;
    logic read_en_d;

    logic [address_width-1:0] address_r;
    logic [data_width-1:0] data_r;
    logic [address_width-1:0] write_address_q;

    logic write_rise;
    logic read_rise;
    logic read_starting;
    logic cop_grant;

    // two stages on each strobe for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            write_en_r <= 1'b0;
            write_en_d <= 1'b0;
            read_en_r <= 1'b0;
            read_en_d <= 1'b0;
        end else begin
            write_en_r <= write_en;
            write_en_d <= write_en_r;
            read_en_r <= read_en;
            read_en_d <= read_en_r;
        end
    end

    // bus payload captured alongside the first strobe stage
    always_ff @(posedge clk) begin
        address_r <= address;
        data_r <= data_in;
    end

    assign write_rise = write_en_r && !write_en_d;
    assign read_rise = read_en_r && !read_en_d;

    // a read strobe follows next cycle and needs the address lines to itself
    assign read_starting = read_en && !read_en_r;

    // accept is still high in the cycle the copper retires its request
    assign cop_grant = cop_write_en && !cop_write_accept && !write_rise && !read_starting;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
            reg_write_en <= 1'b0;
            cop_write_accept <= 1'b0;
        end else begin
            ready <= write_rise || read_rise;
            reg_write_en <= write_rise || cop_grant;
            cop_write_accept <= cop_grant;
        end
    end

    // CPU first, copper only in a free cycle
    always_ff @(posedge clk) begin
        if (write_rise) begin
            write_address_q <= address_r;
            reg_write_data <= data_r;
        end else if (cop_grant) begin
            write_address_q <= cop_write_address;
            reg_write_data <= cop_write_data;
        end
    end

    // the register file latches read data on the edge that ends this strobe
    assign read_strobe = read_rise;
    assign reg_write_address = read_strobe ? address_r : write_address_q;

endmodule

`default_nettype wire

/* vdp_copper.sv */
// Copper co-processor running a program from its own RAM, starting at word 0.
// The program RAM has no reset and must be loaded before the copper is started.
// Writes to the copper ports (32 to 34) are dropped. Stop discards a pending write.
// The program counter wraps at cop_ram_depth, which must be a power of two.
`timescale 1ns/1ps
`default_nettype none

module vdp_copper #(
    parameter int cop_ram_depth = 64
) (
    input  logic clk,
    input  logic reset,

    input  logic [vdp_copper_pkg::raster_width-1:0] raster_line,

    // program RAM fill port
    input  logic cop_ram_write_en,
    input  logic [$clog2(cop_ram_depth)-1:0] cop_ram_write_address,
    input  logic [vdp_regs_pkg::data_width-1:0] cop_ram_write_data,

    input  logic cop_start,
    input  logic cop_stop,

    // register write request
    output logic cop_write_en,
    output logic [vdp_regs_pkg::address_width-1:0] cop_write_address,
    output logic [vdp_regs_pkg::data_width-1:0] cop_write_data,
    input  logic cop_write_accept,

    output logic cop_running,
    output logic cop_halted
);
    import vdp_regs_pkg::*;
    import vdp_copper_pkg::*;

    localparam int pc_width = $clog2(cop_ram_depth);

    localparam logic [2:0] st_stopped = 3'd0;
    localparam logic [2:0] st_decode  = 3'd1;
    localparam logic [2:0] st_data    = 3'd2;
    localparam logic [2:0] st_write   = 3'd3;
    localparam logic [2:0] st_wait    = 3'd4;
    localparam logic [2:0] st_halted  = 3'd5;

    logic [data_width-1:0] ram [cop_ram_depth];
    logic [2:0] state;
    logic [pc_width-1:0] pc;
    copper_word_t word;
    logic [raster_width-1:0] wait_line;
    logic target_blocked;

    always_ff @(posedge clk) begin
        if (cop_ram_write_en) begin
            ram[cop_ram_write_address] <= cop_ram_write_data;
        end
    end

    // asynchronous read, one word per cycle
    assign word = ram[pc];

    // copper may not touch its own control ports
    assign target_blocked = (cop_write_address >= cop_ram_address_reg) &&
                            (cop_write_address <= cop_control_reg);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_stopped;
            pc <= '0;
            cop_write_en <= 1'b0;
        end else if (cop_stop) begin
            state <= st_stopped;
            cop_write_en <= 1'b0;
        end else if (cop_start) begin
            state <= st_decode;
            pc <= '0;
            cop_write_en <= 1'b0;
        end else begin
            case (state)
                st_decode: begin
                    case (word.write_view.op)
                        op_write: begin
                            cop_write_address <= word.write_view.address;
                            pc <= pc + 1'b1;
                            state <= st_data;
                        end
                        op_wait: begin
                            wait_line <= word.wait_view.line;
                            pc <= pc + 1'b1;
                            state <= st_wait;
                        end
                        default: state <= st_halted;
                    endcase
                end
                st_data: begin
                    // second word of a write is the data itself
                    cop_write_data <= word;
                    pc <= pc + 1'b1;
                    if (target_blocked) begin
                        state <= st_decode;
                    end else begin
                        cop_write_en <= 1'b1;
                        state <= st_write;
                    end
                end
                st_write: begin
                    // stall here while the CPU owns the write port
                    if (cop_write_accept) begin
                        cop_write_en <= 1'b0;
                        state <= st_decode;
                    end
                end
                st_wait: begin
                    if (raster_line >= wait_line) begin
                        state <= st_decode;
                    end
                end
                default: ;
            endcase
        end
    end

    assign cop_running = (state != st_stopped) && (state != st_halted);
    assign cop_halted = (state == st_halted);

endmodule

`default_nettype wire

/* vdp_register_file.sv */
// Holds the 32 VDP registers and decodes the copper ports at addresses 32 to 34.
// Reads are latched on the edge that ends read_strobe. Addresses 35 to 63
// read zero, and the copper pointer and data ports read zero too.
`timescale 1ns/1ps
`default_nettype none

module vdp_register_file #(
    parameter int cop_ram_depth = 64
) (
    input  logic clk,
    input  logic reset,

    input  logic reg_write_en,
    input  logic [vdp_regs_pkg::address_width-1:0] reg_write_address,
    input  logic [vdp_regs_pkg::data_width-1:0] reg_write_data,
    input  logic read_strobe,
    output logic [vdp_regs_pkg::data_width-1:0] read_data,

    // copper program load and control
    output logic cop_ram_write_en,
    output logic [$clog2(cop_ram_depth)-1:0] cop_ram_write_address,
    output logic [vdp_regs_pkg::data_width-1:0] cop_ram_write_data,
    output logic cop_start,
    output logic cop_stop,
    input  logic cop_running,
    input  logic cop_halted
);
    import vdp_regs_pkg::*;

    localparam int reg_index_width = $clog2(vdp_register_count);

    logic [data_width-1:0] regs [vdp_register_count];
    logic [$clog2(cop_ram_depth)-1:0] ram_pointer;
    logic [data_width-1:0] cop_status;

    always_comb begin
        cop_status = '0;
        cop_status[cop_status_running_bit] = cop_running;
        cop_status[cop_status_halted_bit] = cop_halted;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < vdp_register_count; i++) begin
                regs[i] <= '0;
            end
            ram_pointer <= '0;
            cop_ram_write_en <= 1'b0;
            cop_start <= 1'b0;
            cop_stop <= 1'b0;
            read_data <= '0;
        end else begin
            cop_ram_write_en <= 1'b0;
            cop_start <= 1'b0;
            cop_stop <= 1'b0;

            if (reg_write_en) begin
                if (reg_write_address < vdp_register_count) begin
                    regs[reg_write_address[reg_index_width-1:0]] <= reg_write_data;
                end else if (reg_write_address == cop_ram_address_reg) begin
                    ram_pointer <= reg_write_data[$clog2(cop_ram_depth)-1:0];
                end else if (reg_write_address == cop_ram_data_reg) begin
                    // auto-increment so a program loads as a burst of data writes
                    cop_ram_write_en <= 1'b1;
                    ram_pointer <= ram_pointer + 1'b1;
                end else if (reg_write_address == cop_control_reg) begin
                    cop_start <= reg_write_data[cop_control_start_bit];
                    cop_stop <= !reg_write_data[cop_control_start_bit];
                end
            end

            if (read_strobe) begin
                if (reg_write_address < vdp_register_count) begin
                    read_data <= regs[reg_write_address[reg_index_width-1:0]];
                end else if (reg_write_address == cop_control_reg) begin
                    read_data <= cop_status;
                end else begin
                    read_data <= '0;
                end
            end
        end
    end

    // RAM word goes out with the pointer value before the increment
    always_ff @(posedge clk) begin
        if (reg_write_en && (reg_write_address == cop_ram_data_reg)) begin
            cop_ram_write_address <= ram_pointer;
            cop_ram_write_data <= reg_write_data;
        end
    end

endmodule

`default_nettype wire

/* vdp_register_subsystem.sv */
// Register front end of the VDP: host interface, copper and register file.
// The merged register write port is exposed for the video core.
// cop_ram_depth must be a power of two. No latency is added at this level.
`timescale 1ns/1ps
`default_nettype none

module vdp_register_subsystem #(
    parameter int cop_ram_depth = 64
) (
    input  logic clk,
    input  logic reset,

    // CPU bus
    input  logic write_en,
    input  logic read_en,
    input  logic [vdp_regs_pkg::address_width-1:0] address,
    input  logic [vdp_regs_pkg::data_width-1:0] data_in,
    output logic ready,
    output logic [vdp_regs_pkg::data_width-1:0] read_data,

    input  logic [vdp_copper_pkg::raster_width-1:0] raster_line,

    // merged register write port
    output logic reg_write_en,
    output logic [vdp_regs_pkg::address_width-1:0] reg_write_address,
    output logic [vdp_regs_pkg::data_width-1:0] reg_write_data
);
    import vdp_regs_pkg::*;

    logic read_strobe;

    // copper write request
    logic cop_write_en;
    logic [address_width-1:0] cop_write_address;
    logic [data_width-1:0] cop_write_data;
    logic cop_write_accept;

    // copper program load and control
    logic cop_ram_write_en;
    logic [$clog2(cop_ram_depth)-1:0] cop_ram_write_address;
    logic [data_width-1:0] cop_ram_write_data;
    logic cop_start;
    logic cop_stop;
    logic cop_running;
    logic cop_halted;

    vdp_host_interface host_interface_i (
        .clk               (clk),
        .reset             (reset),
        .write_en          (write_en),
        .read_en           (read_en),
        .address           (address),
        .data_in           (data_in),
        .ready             (ready),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .cop_write_accept  (cop_write_accept),
        .reg_write_en      (reg_write_en),
        .reg_write_address (reg_write_address),
        .reg_write_data    (reg_write_data),
        .read_strobe       (read_strobe)
    );

    vdp_copper #(
        .cop_ram_depth (cop_ram_depth)
    ) copper_i (
        .clk                   (clk),
        .reset                 (reset),
        .raster_line           (raster_line),
        .cop_ram_write_en      (cop_ram_write_en),
        .cop_ram_write_address (cop_ram_write_address),
        .cop_ram_write_data    (cop_ram_write_data),
        .cop_start             (cop_start),
        .cop_stop              (cop_stop),
        .cop_write_en          (cop_write_en),
        .cop_write_address     (cop_write_address),
        .cop_write_data        (cop_write_data),
        .cop_write_accept      (cop_write_accept),
        .cop_running           (cop_running),
        .cop_halted            (cop_halted)
    );

    vdp_register_file #(
        .cop_ram_depth (cop_ram_depth)
    ) register_file_i (
        .clk                   (clk),
        .reset                 (reset),
        .reg_write_en          (reg_write_en),
        .reg_write_address     (reg_write_address),
        .reg_write_data        (reg_write_data),
        .read_strobe           (read_strobe),
        .read_data             (read_data),
        .cop_ram_write_en      (cop_ram_write_en),
        .cop_ram_write_address (cop_ram_write_address),
        .cop_ram_write_data    (cop_ram_write_data),
        .cop_start             (cop_start),
        .cop_stop              (cop_stop),
        .cop_running           (cop_running),
        .cop_halted            (cop_halted)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset source.
// Reset is high from time zero and drops on the falling edge after reset_cycles edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* vdp_register_subsystem_properties.sv */
// Protocol properties for the host interface, bound into every instance of it.
// failure_count is read by the testbench to decide the end of the run.
`timescale 1ns/1ps
`default_nettype none

module vdp_register_subsystem_properties (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic reg_write_en,
    input logic read_strobe,
    input logic cop_write_en,
    input logic cop_write_accept
);

    int failure_count = 0;

    // one ready pulse per access
    assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
        else begin
            $error("ready stayed high for more than one cycle");
            failure_count = failure_count + 1;
        end

    // a CPU write is a write pulse without copper accept
    assert property (@(posedge clk) disable iff (reset)
        (reg_write_en && !cop_write_accept) |=> !(reg_write_en && !cop_write_accept))
        else begin
            $error("CPU write pulse lasted two cycles");
            failure_count = failure_count + 1;
        end

    assert property (@(posedge clk) disable iff (reset) cop_write_accept |-> cop_write_en)
        else begin
            $error("copper write accepted without a pending request");
            failure_count = failure_count + 1;
        end

    // all strobes quiet while reset is applied
    assert property (@(posedge clk)
        reset |=> !(ready || reg_write_en || read_strobe || cop_write_en || cop_write_accept))
        else begin
            $error("strobe active during reset");
            failure_count = failure_count + 1;
        end

endmodule

bind vdp_host_interface vdp_register_subsystem_properties host_props_i (
    .clk              (clk),
    .reset            (reset),
    .ready            (ready),
    .reg_write_en     (reg_write_en),
    .read_strobe      (read_strobe),
    .cop_write_en     (cop_write_en),
    .cop_write_accept (cop_write_accept)
);

`default_nettype wire

/* vdp_register_subsystem_tb.sv */
// Random CPU traffic and a copper program, checked against a register model.
// CPU writes and reads must complete at fixed cycles; copper writes are matched
// in program order against a queue. Raster line only ever increases.
`timescale 1ns/1ps
`default_nettype none

module vdp_register_subsystem_tb;
    import vdp_regs_pkg::*;
    import vdp_copper_pkg::*;

    localparam int phase1_accesses = 48;
    localparam int high_reads = 8;
    localparam int cop_writes = 6;
    localparam int line_step_max = 29;
    localparam int program_words = cop_writes * 3 + 3;
    localparam int access_cycles = 4;
    localparam int traffic_cycles = (cop_writes * line_step_max + 8) * (4 + access_cycles);
    localparam int timeout_cycles = 4 + traffic_cycles + 100 +
        access_cycles * (phase1_accesses + high_reads + program_words + 2 + 10 + 32);

    logic clk;
    logic reset;
    logic write_en;
    logic read_en;
    logic [address_width-1:0] address;
    logic [data_width-1:0] data_in;
    logic [raster_width-1:0] raster_line;
    logic ready;
    logic [data_width-1:0] read_data;
    logic reg_write_en;
    logic [address_width-1:0] reg_write_address;
    logic [data_width-1:0] reg_write_data;

    int cycle = 0;
    logic [31:0] lcg_state = 32'hbcc26fa4;
    logic [data_width-1:0] model_regs [vdp_register_count];
    logic [data_width-1:0] cop_status_exp = '0;

    // expected CPU writes with the cycle they must appear in
    int cpu_cycle_q[$];
    logic [address_width-1:0] cpu_addr_q[$];
    logic [data_width-1:0] cpu_data_q[$];

    // expected copper writes in program order
    logic [address_width-1:0] cop_addr_q[$];
    logic [data_width-1:0] cop_data_q[$];
    logic [raster_width-1:0] cop_line_q[$];
    logic [data_width-1:0] program_q[$];

    tb_clock_gen #(.period_ns(100), .reset_cycles(4)) clock_i (.clk(clk), .reset(reset));

    vdp_register_subsystem #(.cop_ram_depth(64)) dut_i (
        .clk               (clk),
        .reset             (reset),
        .write_en          (write_en),
        .read_en           (read_en),
        .address           (address),
        .data_in           (data_in),
        .raster_line       (raster_line),
        .ready             (ready),
        .read_data         (read_data),
        .reg_write_en      (reg_write_en),
        .reg_write_address (reg_write_address),
        .reg_write_data    (reg_write_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    // upper LCG bits, the low ones have short periods
    function automatic int unsigned random_below(input int unsigned limit);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16] % limit;
    endfunction

    function automatic logic [data_width-1:0] expected_read(input logic [address_width-1:0] addr);
        if (addr < vdp_register_count) begin
            return model_regs[addr[4:0]];
        end else if (addr == cop_control_reg) begin
            return cop_status_exp;
        end
        return '0;
    endfunction

    task automatic cpu_write(input logic [address_width-1:0] addr,
                             input logic [data_width-1:0] data);
        int waited;
        @(negedge clk);
        write_en = 1'b1;
        address = addr;
        data_in = data;
        cpu_cycle_q.push_back(cycle + 2);
        cpu_addr_q.push_back(addr);
        cpu_data_q.push_back(data);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ready && waited < 8);
        assert (ready) else abort_run("ready did not follow a CPU write");
        assert (waited == 2) else value_error("write ready latency", waited, 2);
        write_en = 1'b0;
        if (addr < vdp_register_count) begin
            model_regs[addr[4:0]] = data;
        end
    endtask

    task automatic cpu_read(input logic [address_width-1:0] addr,
                            output logic [data_width-1:0] data);
        int waited;
        @(negedge clk);
        read_en = 1'b1;
        address = addr;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ready && waited < 8);
        assert (ready) else abort_run("ready did not follow a CPU read");
        assert (waited == 2) else value_error("read ready latency", waited, 2);
        data = read_data;
        read_en = 1'b0;
        // read data must hold after ready
        @(negedge clk);
        assert (read_data == data) else value_error("read_data hold", read_data, data);
    endtask

    task automatic check_read(input logic [address_width-1:0] addr);
        logic [data_width-1:0] value;
        cpu_read(addr, value);
        assert (value == expected_read(addr))
            else value_error("read_data", value, expected_read(addr));
    endtask

    // waits with rising lines, each followed by a write to registers 0 to 15
    task automatic build_program();
        logic [raster_width-1:0] line;
        logic [address_width-1:0] addr;
        logic [data_width-1:0] data;
        line = '0;
        for (int k = 0; k < cop_writes; k++) begin
            line = line + 10 + random_below(20);
            addr = random_below(16);
            data = random_below(65536);
            program_q.push_back({op_wait, 4'b0000, line});
            program_q.push_back({op_write, 8'h00, addr});
            program_q.push_back(data);
            cop_addr_q.push_back(addr);
            cop_data_q.push_back(data);
            cop_line_q.push_back(line);
            if (k == 2) begin
                // the copper must drop this one
                program_q.push_back({op_write, 8'h00, cop_ram_data_reg});
                program_q.push_back(random_below(65536));
            end
        end
        program_q.push_back({op_halt, 14'h0000});
    endtask

    task automatic check_copper_write();
        assert (reg_write_address < cop_ram_address_reg || reg_write_address > cop_control_reg)
            else abort_run("copper write to a copper port reached the register write port");
        assert (cop_addr_q.size() > 0) else abort_run("unexpected write on the register write port");
        assert (reg_write_address == cop_addr_q[0])
            else value_error("reg_write_address", reg_write_address, cop_addr_q[0]);
        assert (reg_write_data == cop_data_q[0])
            else value_error("reg_write_data", reg_write_data, cop_data_q[0]);
        assert (raster_line >= cop_line_q[0])
            else abort_run($sformatf("copper write at raster line %0d before its wait line %0d",
                                     raster_line, cop_line_q[0]));
        model_regs[cop_addr_q[0][4:0]] = cop_data_q[0];
        void'(cop_addr_q.pop_front());
        void'(cop_data_q.pop_front());
        void'(cop_line_q.pop_front());
    endtask

    // register write port monitor, cycle counter and timeout
    always @(posedge clk) begin
        if (!reset) begin
            if (cpu_cycle_q.size() > 0 && cpu_cycle_q[0] == cycle) begin
                assert (reg_write_en) else abort_run("CPU write missing from the write port");
                assert (reg_write_address == cpu_addr_q[0])
                    else value_error("reg_write_address", reg_write_address, cpu_addr_q[0]);
                assert (reg_write_data == cpu_data_q[0])
                    else value_error("reg_write_data", reg_write_data, cpu_data_q[0]);
                void'(cpu_cycle_q.pop_front());
                void'(cpu_addr_q.pop_front());
                void'(cpu_data_q.pop_front());
            end else if (reg_write_en) begin
                check_copper_write();
            end
        end
        assert (dut_i.host_interface_i.host_props_i.failure_count == 0)
            else abort_run("a host interface protocol assertion failed");
        cycle++;
        assert (cycle <= timeout_cycles)
            else abort_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
    end

    initial begin
        logic [data_width-1:0] value;
        int tries;
        int gap;
        write_en = 1'b0;
        read_en = 1'b0;
        address = '0;
        data_in = '0;
        raster_line = '0;
        for (int i = 0; i < vdp_register_count; i++) begin
            model_regs[i] = '0;
        end
        @(negedge clk);
        while (reset) @(negedge clk);

        // random register traffic with the copper stopped
        repeat (phase1_accesses) begin
            if (random_below(3) != 0) begin
                cpu_write(random_below(32), random_below(65536));
            end else begin
                check_read(random_below(64));
            end
        end
        repeat (high_reads) check_read(35 + random_below(29));

        // load the program from word 0 and start it
        build_program();
        cpu_write(cop_ram_address_reg, '0);
        foreach (program_q[i]) cpu_write(cop_ram_data_reg, program_q[i]);
        cpu_write(cop_control_reg, 16'h0001);

        // CPU writes to the upper registers while the raster advances
        while (cop_addr_q.size() > 0) begin
            gap = 1 + random_below(4);
            repeat (gap) begin
                @(negedge clk);
                if (raster_line < 1000) begin
                    raster_line = raster_line + 1 + random_below(4);
                end
            end
            cpu_write(16 + random_below(16), random_below(65536));
        end

        // poll the control register until the copper reports halt
        tries = 0;
        do begin
            cpu_read(cop_control_reg, value);
            tries++;
        end while (!value[cop_status_halted_bit] && tries < 10);
        cop_status_exp[cop_status_halted_bit] = 1'b1;
        assert (value == cop_status_exp) else value_error("read_data", value, cop_status_exp);

        for (int i = 0; i < vdp_register_count; i++) begin
            check_read(i);
        end

        if (dut_i.host_interface_i.host_props_i.failure_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("a host interface protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

/* vdp_register_subsystem.f */
vdp_regs_pkg.sv
vdp_copper_pkg.sv
vdp_host_interface.sv
vdp_copper.sv
vdp_register_file.sv
vdp_register_subsystem.sv
tb_clock_gen.sv
vdp_register_subsystem_properties.sv
vdp_register_subsystem_tb.sv
